//--- src/intc_pkg.sv
package intc_pkg;

    // the controller has a fixed map of four sources
    localparam int num_sources = 4;
    localparam int src_idx_w = 2;

    // vector addresses and Wishbone data share one width
    localparam int vec_w = 32;

    // Wishbone word address
    localparam int adr_w = 3;

    // per-source service-routine addresses, read-write
    localparam logic [adr_w-1:0] reg_vec0 = 3'd0;
    localparam logic [adr_w-1:0] reg_vec1 = 3'd1;
    localparam logic [adr_w-1:0] reg_vec2 = 3'd2;
    localparam logic [adr_w-1:0] reg_vec3 = 3'd3;

    // enable mask sits in the low num_sources bits
    localparam logic [adr_w-1:0] reg_enable = 3'd4;

    // read gives pending bits, write of a one clears that bit
    localparam logic [adr_w-1:0] reg_pending = 3'd5;

    // read only, irq in bit 31 and the selected index in the low bits
    localparam logic [adr_w-1:0] reg_active = 3'd6;

endpackage

//--- src/intc_pending.sv
`timescale 1ns/100ps

module intc_pending (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [intc_pkg::num_sources-1:0] done,
    input  logic [intc_pkg::num_sources-1:0] ack_clear,
    input  logic [intc_pkg::num_sources-1:0] sw_clear,
    output logic [intc_pkg::num_sources-1:0] pending
);
    import intc_pkg::*;

    logic [num_sources-1:0] clear_any;
    logic [num_sources-1:0] pending_next;

    // either clear path removes a bit, acknowledge or software write
    assign clear_any = ack_clear | sw_clear;

    // a source that is still asserting done stays pending even while it is
    // being cleared, so a held line is never lost
    always_comb begin
        pending_next = pending;
        for (int i = 0; i < num_sources; i++) begin
            if (done[i]) begin
                pending_next[i] = 1'b1;
            end else if (clear_any[i]) begin
                pending_next[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

    // the dispatch block acknowledges only the presented source
    property p_ack_clear_onehot;
        @(posedge clk) disable iff (rst)
        $onehot0(ack_clear);
    endproperty

    a_ack_clear_onehot : assert property (p_ack_clear_onehot)
        else $error("acknowledge clear has more than one bit set: %b", ack_clear);

    // every source seen high at an edge is pending after that edge
    property p_done_sets_pending;
        @(posedge clk) disable iff (rst)
        (done != '0) |=> ((pending & $past(done)) == $past(done));
    endproperty

    a_done_sets_pending : assert property (p_done_sets_pending)
        else $error("done %b did not latch, pending is %b", $past(done), pending);

endmodule

//--- src/intc_wb_regs.sv
`timescale 1ns/100ps

module intc_wb_regs (
    input  logic                             clk,
    input  logic                             rst,

    // Wishbone classic slave
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [intc_pkg::adr_w-1:0]       wb_adr,
    input  logic [intc_pkg::vec_w-1:0]       wb_dat_w,
    output logic [intc_pkg::vec_w-1:0]       wb_dat_r,
    output logic                             wb_ack,

    // status from the other blocks
    input  logic [intc_pkg::num_sources-1:0] pending,
    input  logic                             irq,
    input  logic [intc_pkg::src_idx_w-1:0]   src_sel,

    // configuration out to dispatch and pending
    output logic [intc_pkg::num_sources-1:0] enable_mask,
    output logic [intc_pkg::vec_w-1:0]       vec0,
    output logic [intc_pkg::vec_w-1:0]       vec1,
    output logic [intc_pkg::vec_w-1:0]       vec2,
    output logic [intc_pkg::vec_w-1:0]       vec3,
    output logic [intc_pkg::num_sources-1:0] sw_clear
);
    import intc_pkg::*;

    logic             wb_req;
    logic             wr_req;
    logic             rd_req;
    logic [vec_w-1:0] rd_data;

    // a request that is being acknowledged this cycle is not seen again,
    // so a strobe held across the acknowledge is served every second cycle
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = wb_req && wb_we;
    assign rd_req = wb_req && !wb_we;

    // the clear pulse lasts exactly as long as the request, which is one cycle
    always_comb begin
        sw_clear = '0;
        if (wr_req && (wb_adr == reg_pending)) begin
            sw_clear = wb_dat_w[num_sources-1:0];
        end
    end

    // read mux, sampled into wb_dat_r at the acknowledging edge
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            reg_vec0: rd_data = vec0;
            reg_vec1: rd_data = vec1;
            reg_vec2: rd_data = vec2;
            reg_vec3: rd_data = vec3;
            reg_enable: begin
                rd_data = {{(vec_w - num_sources){1'b0}}, enable_mask};
            end
            reg_pending: begin
                rd_data = {{(vec_w - num_sources){1'b0}}, pending};
            end
            reg_active: begin
                rd_data = {irq, {(vec_w - 1 - src_idx_w){1'b0}}, src_sel};
            end
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            enable_mask <= '0;
            vec0        <= '0;
            vec1        <= '0;
            vec2        <= '0;
            vec3        <= '0;
        end else begin
            wb_ack <= wb_req;
            if (wr_req) begin
                case (wb_adr)
                    reg_vec0:   vec0 <= wb_dat_w;
                    reg_vec1:   vec1 <= wb_dat_w;
                    reg_vec2:   vec2 <= wb_dat_w;
                    reg_vec3:   vec3 <= wb_dat_w;
                    reg_enable: enable_mask <= wb_dat_w[num_sources-1:0];
                    default:    ;
                endcase
            end
        end
    end

    // read data is captured as a read is taken and holds until the next read
    always_ff @(posedge clk) begin
        if (rd_req) begin
            wb_dat_r <= rd_data;
        end
    end

    // the slave never holds its acknowledge for more than one cycle
    property p_ack_single;
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack;
    endproperty

    a_ack_single : assert property (p_ack_single)
        else $error("wb_ack high in two consecutive cycles");

    // an acknowledge answers a request seen at the previous edge
    property p_ack_after_req;
        @(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb);
    endproperty

    a_ack_after_req : assert property (p_ack_after_req)
        else $error("wb_ack without a preceding request");

endmodule

//--- src/intc_dispatch.sv
`timescale 1ns/100ps

module intc_dispatch (
    input  logic [intc_pkg::num_sources-1:0] pending,
    input  logic [intc_pkg::num_sources-1:0] enable_mask,
    input  logic [intc_pkg::vec_w-1:0]       vec0,
    input  logic [intc_pkg::vec_w-1:0]       vec1,
    input  logic [intc_pkg::vec_w-1:0]       vec2,
    input  logic [intc_pkg::vec_w-1:0]       vec3,
    input  logic                             iack,
    output logic                             irq,
    output logic [intc_pkg::src_idx_w-1:0]   src_sel,
    output logic [intc_pkg::vec_w-1:0]       isr_addr,
    output logic [intc_pkg::num_sources-1:0] ack_clear
);
    import intc_pkg::*;

    logic [num_sources-1:0] active;

    // masked sources stay pending but never reach the processor
    assign active = pending & enable_mask;
    assign irq    = |active;

    // priority encoder, walking down so the lowest index is written last
    // and therefore wins; stays at zero when nothing is active
    always_comb begin
        src_sel = '0;
        for (int i = num_sources - 1; i >= 0; i--) begin
            if (active[i]) begin
                src_sel = src_idx_w'(i);
            end
        end
    end

    // service-routine address of the presented source
    always_comb begin
        case (src_sel)
            2'd0: isr_addr = vec0;
            2'd1: isr_addr = vec1;
            2'd2: isr_addr = vec2;
            2'd3: isr_addr = vec3;
            default: isr_addr = vec0;
        endcase
    end

    // iack only clears the source that is actually presented, and is
    // ignored when no interrupt is raised
    always_comb begin
        ack_clear = '0;
        if (iack && irq) begin
            ack_clear[src_sel] = 1'b1;
        end
    end

    // the presented index must point at an enabled, pending source
    // whenever the processor is interrupted
    always_comb begin
        a_sel_is_active : assert final (!irq || (pending[src_sel] && enable_mask[src_sel]))
            else $error("irq raised but source %0d is not pending and enabled", src_sel);
    end

endmodule

//--- src/intc_top.sv
`timescale 1ns/100ps

module intc_top (
    input  logic                             clk,
    input  logic                             rst,

    // interrupt sources and processor acknowledge
    input  logic [intc_pkg::num_sources-1:0] done,
    input  logic                             iack,

    // Wishbone classic configuration port
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [intc_pkg::adr_w-1:0]       wb_adr,
    input  logic [intc_pkg::vec_w-1:0]       wb_dat_w,
    output logic [intc_pkg::vec_w-1:0]       wb_dat_r,
    output logic                             wb_ack,

    // to the processor
    output logic                             irq,
    output logic [intc_pkg::src_idx_w-1:0]   src_sel,
    output logic [intc_pkg::vec_w-1:0]       isr_addr
);
    import intc_pkg::*;

    logic [num_sources-1:0] pending;
    logic [num_sources-1:0] enable_mask;
    logic [num_sources-1:0] ack_clear;
    logic [num_sources-1:0] sw_clear;
    logic [vec_w-1:0]       vec0;
    logic [vec_w-1:0]       vec1;
    logic [vec_w-1:0]       vec2;
    logic [vec_w-1:0]       vec3;

    intc_pending u_pending (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .ack_clear (ack_clear),
        .sw_clear  (sw_clear),
        .pending   (pending)
    );

    intc_wb_regs u_wb_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .pending     (pending),
        .irq         (irq),
        .src_sel     (src_sel),
        .enable_mask (enable_mask),
        .vec0        (vec0),
        .vec1        (vec1),
        .vec2        (vec2),
        .vec3        (vec3),
        .sw_clear    (sw_clear)
    );

    intc_dispatch u_dispatch (
        .pending     (pending),
        .enable_mask (enable_mask),
        .vec0        (vec0),
        .vec1        (vec1),
        .vec2        (vec2),
        .vec3        (vec3),
        .iack        (iack),
        .irq         (irq),
        .src_sel     (src_sel),
        .isr_addr    (isr_addr),
        .ack_clear   (ack_clear)
    );

endmodule

//--- bench/intc_tb.sv
`timescale 1ns/100ps

module intc_tb;
    import intc_pkg::*;

    localparam int ack_timeout = 16;
    localparam logic [1:0] act_none = 2'd0;
    localparam logic [1:0] act_iack = 2'd1;
    localparam logic [1:0] act_swclr = 2'd2;

    // one table row: enable mask, one-cycle done pattern, then an action with
    // its clear mask and a done pattern held high while the action runs
    typedef struct packed {
        logic [3:0] enable;
        logic [3:0] done_pat;
        logic [1:0] action;
        logic [3:0] arg;
        logic [3:0] hold;
    } step_t;

    localparam int num_steps = 16;

    step_t steps [num_steps] = '{
        '{4'b1111, 4'b1010, act_none, 4'b0000, 4'b0000},
        '{4'b1101, 4'b0100, act_none, 4'b0000, 4'b0000},
        '{4'b0000, 4'b0000, act_none, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0001, act_iack, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0000, act_iack, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0000, act_iack, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0000, act_iack, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0000, act_iack, 4'b0000, 4'b0000},
        '{4'b0011, 4'b1100, act_iack, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0011, act_swclr, 4'b0101, 4'b0000},
        '{4'b1111, 4'b0000, act_swclr, 4'b1000, 4'b1000},
        '{4'b1111, 4'b0100, act_iack, 4'b0000, 4'b0010},
        '{4'b1111, 4'b0000, act_iack, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0000, act_swclr, 4'b1111, 4'b0000},
        '{4'b0100, 4'b1111, act_none, 4'b0000, 4'b0000},
        '{4'b1111, 4'b0000, act_swclr, 4'b1111, 4'b0000}
    };

    logic                   clk = 1'b0;
    logic                   rst;
    logic [num_sources-1:0] done;
    logic                   iack;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [adr_w-1:0]       wb_adr;
    logic [vec_w-1:0]       wb_dat_w;
    logic [vec_w-1:0]       wb_dat_r;
    logic                   wb_ack;
    logic                   irq;
    logic [src_idx_w-1:0]   src_sel;
    logic [vec_w-1:0]       isr_addr;

    // reference state of the controller
    logic [num_sources-1:0] model_pending;
    logic [num_sources-1:0] model_enable;
    logic [vec_w-1:0]       model_vec [num_sources];
    logic [31:0]            rng_state = 32'h3a34_0d10;

    intc_top dut (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .iack     (iack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq),
        .src_sel  (src_sel),
        .isr_addr (isr_addr)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // index 0 has the highest priority
    function automatic int lowest_index(input logic [num_sources-1:0] bits);
        int idx;
        bit found;
        idx = 0;
        found = 1'b0;
        for (int i = 0; i < num_sources; i++) begin
            if (bits[i] && !found) begin
                idx = i;
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t signal %s actual %h expected %h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ack is registered, so it is looked at on the falling edge
    task automatic wait_for_ack(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ack_timeout) begin
                $display("no Wishbone acknowledge for the %s", what);
                abort_run();
            end
        end while (!wb_ack);
    endtask

    task automatic wb_write(input logic [adr_w-1:0] adr, input logic [vec_w-1:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        wait_for_ack("write");
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic read_expect(input logic [adr_w-1:0] adr, input logic [vec_w-1:0] expected,
                               input string name);
        logic [vec_w-1:0] data;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_for_ack("read");
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        check_value(name, data, expected);
    endtask

    // compares the processor-side outputs and the status registers with the model
    task automatic check_outputs();
        logic [num_sources-1:0] active;
        logic                   exp_irq;
        int                     exp_sel;
        active = model_pending & model_enable;
        exp_irq = |active;
        exp_sel = exp_irq ? lowest_index(active) : 0;
        check_value("irq", 32'(irq), 32'(exp_irq));
        check_value("src_sel", 32'(src_sel), exp_sel);
        if (exp_irq) begin
            check_value("isr_addr", isr_addr, model_vec[exp_sel]);
        end
        read_expect(reg_pending, 32'(model_pending), "reg_pending");
        read_expect(reg_active, {exp_irq, 29'd0, 2'(exp_sel)}, "reg_active");
    endtask

    initial begin
        rst = 1'b1;
        done = '0;
        iack = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        model_pending = '0;
        model_enable = '0;
        for (int i = 0; i < num_sources; i++) begin
            model_vec[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // everything reads back as zero after reset, unused offset 7 too
        @(negedge clk);
        check_value("irq", 32'(irq), 32'd0);
        check_value("src_sel", 32'(src_sel), 32'd0);
        for (int a = 0; a < 8; a++) begin
            read_expect(adr_w'(a), '0, "wb_dat_r");
        end

        // random vectors and an enable mask, read back unchanged
        for (int i = 0; i < num_sources; i++) begin
            rng_state = xorshift32(rng_state);
            model_vec[i] = rng_state;
            wb_write(reg_vec0 + adr_w'(i), model_vec[i]);
        end
        model_enable = 4'b1011;
        wb_write(reg_enable, 32'h0000_000b);
        wb_write(3'd7, 32'hffff_ffff);
        for (int i = 0; i < num_sources; i++) begin
            read_expect(reg_vec0 + adr_w'(i), model_vec[i], "vector register");
        end
        read_expect(reg_enable, 32'h0000_000b, "reg_enable");
        read_expect(3'd7, '0, "unused offset");

        for (int s = 0; s < num_steps; s++) begin
            if (steps[s].enable != model_enable) begin
                model_enable = steps[s].enable;
                wb_write(reg_enable, 32'(steps[s].enable));
            end
            @(posedge clk);
            done <= steps[s].done_pat;
            @(posedge clk);
            done <= '0;
            model_pending = model_pending | steps[s].done_pat;
            @(negedge clk);
            check_outputs();

            if (steps[s].action == act_iack) begin
                @(posedge clk);
                iack <= 1'b1;
                done <= steps[s].hold;
                @(posedge clk);
                iack <= 1'b0;
                done <= '0;
                // an iack without irq does nothing
                if ((model_pending & model_enable) != '0) begin
                    model_pending[lowest_index(model_pending & model_enable)] = 1'b0;
                end
                model_pending = model_pending | steps[s].hold;
                @(negedge clk);
                check_outputs();
            end else if (steps[s].action == act_swclr) begin
                @(posedge clk);
                done <= steps[s].hold;
                wb_write(reg_pending, 32'(steps[s].arg));
                done <= '0;
                model_pending = (model_pending & ~steps[s].arg) | steps[s].hold;
                @(negedge clk);
                check_outputs();
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
src/intc_pkg.sv
src/intc_pending.sv
src/intc_wb_regs.sv
src/intc_dispatch.sv
src/intc_top.sv
bench/intc_tb.sv
